/* life_top.f */
+incdir+.
video_pkg.sv
life_pkg.sv
frame_pacer.sv
life_engine.sv
display_timing.sv
world_store.sv
life_top.sv
life_top_asserts.sv
tb_life_top.sv

/* Makefile */
# Verilator build and run of the Game of Life display testbench

VERILATOR ?= verilator
TOP       ?= tb_life_top
FILELIST  ?= life_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) life_params.svh

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, log to $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "no result line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_life_top.sv */
// testbench for the Game of Life display top level
// seeds a world, runs generations and checks every output pixel against a life model
`timescale 1ns/1ps
`include "life_params.svh"

module tb_life_top;
    import life_pkg::*;
    import video_pkg::*;

    localparam int          SHIFT          = `LIFE_SCALE_SHIFT;
    localparam logic [11:0] ALIVE          = `LIFE_ALIVE_COLOR;
    localparam logic [11:0] DEAD           = `LIFE_DEAD_COLOR;
    localparam int          TIMEOUT_CYCLES = 14 * `LIFE_H_TOTAL * `LIFE_V_TOTAL;  // run needs ~12

    logic    clk_pix;
    logic    rst_n;
    logic    run;
    logic    seed_we;
    cell_x_t seed_x;
    cell_y_t seed_y;
    logic    seed_alive;
    logic    hsync;
    logic    vsync;
    logic    de;
    chan_t   red;
    chan_t   green;
    chan_t   blue;
    logic    generation_pulse;

    logic world [`LIFE_WORLD_H][`LIFE_WORLD_W];  // model of the shown world
    int   seed;
    int   tx;             // raster position, as the timing counters
    int   ty;
    int   ox;             // position now shown at the outputs
    int   oy;
    logic out_valid;
    logic run_s;          // run at the last rising edge
    logic check_colour;
    logic seen_pulse;
    int   frames_since;   // output frames since the last pulse
    int   sync_errs;
    int   colour_errs;
    int   pace_errs;
    int   tests_passed;
    int   tests_failed;

    life_top dut0 (
        .clk_pix, .rst_n, .run, .seed_we, .seed_x, .seed_y, .seed_alive,
        .hsync, .vsync, .de, .red, .green, .blue, .generation_pulse
    );

    always #20 clk_pix = ~clk_pix;

    // outputs lag the raster counters by one cycle
    always @(posedge clk_pix) begin
        run_s <= run;
        if (!rst_n) begin
            tx        <= 0;
            ty        <= 0;
            out_valid <= 1'b0;
        end else begin
            ox        <= tx;
            oy        <= ty;
            out_valid <= 1'b1;
            if (tx == `LIFE_H_TOTAL - 1) begin
                tx <= 0;
                ty <= (ty == `LIFE_V_TOTAL - 1) ? 0 : ty + 1;
            end else begin
                tx <= tx + 1;
            end
        end
    end

    // next generation, dead outside the world
    task automatic step_world();
        logic nxt [`LIFE_WORLD_H][`LIFE_WORLD_W];
        int   n;
        for (int y = 0; y < `LIFE_WORLD_H; y++) begin
            for (int x = 0; x < `LIFE_WORLD_W; x++) begin
                n = 0;
                for (int dy = -1; dy <= 1; dy++) begin
                    for (int dx = -1; dx <= 1; dx++) begin
                        if ((dx != 0 || dy != 0) && y + dy >= 0 && y + dy < `LIFE_WORLD_H
                            && x + dx >= 0 && x + dx < `LIFE_WORLD_W)
                            n += int'(world[y + dy][x + dx]);
                    end
                end
                nxt[y][x] = (n == 3) || (world[y][x] && n == 2);  // birth or survival
            end
        end
        world = nxt;
    endtask

    // checks on settled outputs, half a cycle after the rising edge
    always @(negedge clk_pix) begin
        logic [11:0] want;
        logic        want_de;
        logic        want_hs;
        logic        want_vs;
        if (out_valid) begin
            if (generation_pulse)
                step_world();                          // pixel 0,0 shows the new world
            want_de = (ox < `LIFE_H_ACTIVE) && (oy < `LIFE_V_ACTIVE);
            want_hs = (ox >= `LIFE_H_SYNC_START) && (ox < `LIFE_H_SYNC_END);
            want_vs = (oy >= `LIFE_V_SYNC_START) && (oy < `LIFE_V_SYNC_END);
            assert ({de, hsync, vsync} == {want_de, want_hs, want_vs}) else begin
                sync_errs++;
                $display("mismatch at %0t ns: de hsync vsync %b%b%b at (%0d,%0d), expected %b%b%b",
                         $time, de, hsync, vsync, ox, oy, want_de, want_hs, want_vs);
            end
            want = 12'h000;                            // black in blanking
            if (want_de)
                want = world[oy >> SHIFT][ox >> SHIFT] ? ALIVE : DEAD;
            if (check_colour) begin
                assert ({red, green, blue} == want) else begin
                    colour_errs++;
                    $display("mismatch at %0t ns: colour %h at (%0d,%0d), expected %h",
                             $time, {red, green, blue}, ox, oy, want);
                end
            end
            assert (!generation_pulse || (run_s && ox == 0 && oy == 0)) else begin
                pace_errs++;
                $display("generation pulse at %0t ns was not at a running frame start", $time);
            end
            if (ox == 0 && oy == 0) begin
                if (generation_pulse) begin
                    assert (!seen_pulse || frames_since + 1 >= `LIFE_GEN_FRAMES) else begin
                        pace_errs++;
                        $display("generation pulse at %0t ns came too soon after the last one",
                                 $time);
                    end
                    seen_pulse   = 1'b1;
                    frames_since = 0;
                end else begin
                    frames_since++;
                end
            end
        end
    end

    task automatic write_cell(input int x, input int y, input logic alive);
        @(negedge clk_pix);
        seed_we    = 1'b1;
        seed_x     = cell_x_t'(x);
        seed_y     = cell_y_t'(y);
        seed_alive = alive;
        world[y][x] = alive;
    endtask

    // seed writes while running, the world must not change
    task automatic try_locked_writes(input int count);
        int x;
        int y;
        for (int i = 0; i < count; i++) begin
            @(negedge clk_pix);
            x          = {$random(seed)} % `LIFE_WORLD_W;
            y          = {$random(seed)} % `LIFE_WORLD_H;
            seed_we    = 1'b1;
            seed_x     = cell_x_t'(x);
            seed_y     = cell_y_t'(y);
            seed_alive = !world[y][x];                 // would flip the cell
        end
        @(negedge clk_pix);
        seed_we = 1'b0;
    endtask

    task automatic wait_output_frame();
        do @(negedge clk_pix); while (!(out_valid && ox == 0 && oy == 0));
    endtask

    task automatic wait_pulse();
        do @(negedge clk_pix); while (!generation_pulse);
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0)
            tests_passed++;
        else
            tests_failed++;
        $display("%s: %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_pix);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int c0;
        seed         = 44397;
        clk_pix      = 1'b0;
        rst_n        = 1'b0;
        run          = 1'b0;
        seed_we      = 1'b0;
        seed_x       = '0;
        seed_y       = '0;
        seed_alive   = 1'b0;
        out_valid    = 1'b0;
        check_colour = 1'b0;
        seen_pulse   = 1'b0;
        frames_since = 0;
        sync_errs    = 0;
        colour_errs  = 0;
        pace_errs    = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (16) @(negedge clk_pix);
        rst_n = 1'b1;

        for (int y = 0; y < `LIFE_WORLD_H; y++)
            for (int x = 0; x < `LIFE_WORLD_W; x++)
                write_cell(x, y, 1'b0);                // clear the whole world
        for (int x = 2; x <= 4; x++)
            write_cell(x, 2, 1'b1);                    // blinker, row 2
        write_cell(10, 2, 1'b1);                       // 2 x 2 block
        write_cell(11, 2, 1'b1);
        write_cell(10, 3, 1'b1);
        write_cell(11, 3, 1'b1);
        repeat (12)
            write_cell({$random(seed)} % `LIFE_WORLD_W, 7 + {$random(seed)} % 5, 1'b1);
        @(negedge clk_pix);
        seed_we = 1'b0;
        @(negedge clk_pix);
        c0           = colour_errs;
        check_colour = 1'b1;

        wait_output_frame();                           // rest of the seeding frame
        wait_output_frame();                           // one full frame with run low
        report_test("seeded world display", colour_errs - c0);

        run = 1'b1;
        c0  = colour_errs;
        repeat (3) begin
            wait_pulse();
            wait_output_frame();                       // whole frame of the new world
        end
        report_test("life rule over three generations", colour_errs - c0);

        c0 = colour_errs;
        try_locked_writes(40);
        wait_pulse();
        wait_output_frame();
        @(posedge clk_pix);                            // falling edge checks all done
        report_test("seed lockout while running", colour_errs - c0);

        report_test("sync timing", sync_errs);
        report_test("generation pacing", pace_errs);
        report_test("handshake protocol", dut0.asserts_inst.fail_count);
        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* life_top_asserts.sv */
// handshake checks for the Game of Life top level
// bound into life_top, watches the pacer to engine handshake and the swap pulse
`timescale 1ns/1ps

module life_top_asserts (
    input logic clk_pix,
    input logic rst_n,
    input logic gen_req,
    input logic gen_ack,
    input logic gen_done,
    input logic generation_pulse
);
    int fail_count = 0;  // failed checks so far

    req_held: assert property (@(posedge clk_pix) disable iff (!rst_n)
        $fell(gen_req) |-> $past(gen_ack))  // phase 3 only after phase 2
        else begin
            $error("gen_req dropped before gen_ack rose");
            fail_count++;
        end

    ack_needs_req: assert property (@(posedge clk_pix) disable iff (!rst_n)
        $rose(gen_ack) |-> gen_req)
        else begin
            $error("gen_ack rose without gen_req");
            fail_count++;
        end

    done_on_ack: assert property (@(posedge clk_pix) disable iff (!rst_n)
        gen_done |-> $rose(gen_ack))
        else begin
            $error("gen_done outside the rising edge of gen_ack");
            fail_count++;
        end

    ack_has_done: assert property (@(posedge clk_pix) disable iff (!rst_n)
        $rose(gen_ack) |-> gen_done)
        else begin
            $error("gen_ack rose without gen_done");
            fail_count++;
        end

    req_after_ack: assert property (@(posedge clk_pix) disable iff (!rst_n)
        $rose(gen_req) |-> !$past(gen_ack))  // new request waits for phase 4
        else begin
            $error("gen_req raised while gen_ack was still high");
            fail_count++;
        end

    ack_release: assert property (@(posedge clk_pix) disable iff (!rst_n)
        gen_ack && !gen_req |=> !gen_ack)
        else begin
            $error("gen_ack held after gen_req fell");
            fail_count++;
        end

    pulse_single: assert property (@(posedge clk_pix) disable iff (!rst_n)
        generation_pulse |=> !generation_pulse)
        else begin
            $error("generation_pulse longer than one cycle");
            fail_count++;
        end

endmodule

bind life_top life_top_asserts asserts_inst (
    .clk_pix, .rst_n, .gen_req, .gen_ack, .gen_done, .generation_pulse
);

/* life_top.sv */
// Game of Life top level
// frame pacer, life engine, display timing and world store
`timescale 1ns/1ps

module life_top (
    input  logic              clk_pix,
    input  logic              rst_n,
    input  logic              run,         // evolve the world while high
    input  logic              seed_we,     // seed write, only while run is low
    input  life_pkg::cell_x_t seed_x,
    input  life_pkg::cell_y_t seed_y,
    input  logic              seed_alive,
    output logic              hsync,
    output logic              vsync,
    output logic              de,
    output video_pkg::chan_t  red,
    output video_pkg::chan_t  green,
    output video_pkg::chan_t  blue,
    output logic              generation_pulse
);
    import video_pkg::*;
    import life_pkg::*;

    logic       gen_req;
    logic       gen_ack;
    logic       gen_done;
    cell_addr_t rd_addr;
    logic       rd_alive;
    logic       wr_en;
    cell_addr_t wr_addr;
    logic       wr_alive;
    coord_t     sx;
    coord_t     sy;
    logic       timing_hsync;  // undelayed, from the counters
    logic       timing_vsync;
    logic       timing_de;
    logic       frame_start;

    frame_pacer pacer_inst (
        .clk_pix, .rst_n, .run, .frame_start, .gen_ack, .gen_req
    );

    life_engine engine_inst (
        .clk_pix, .rst_n, .gen_req, .rd_alive,
        .gen_ack, .gen_done, .rd_addr, .wr_en, .wr_addr, .wr_alive
    );

    display_timing timing_inst (
        .clk_pix, .rst_n, .sx, .sy,
        .hsync(timing_hsync), .vsync(timing_vsync), .de(timing_de), .frame_start
    );

    world_store store_inst (
        .clk_pix, .rst_n, .run, .seed_we, .seed_x, .seed_y, .seed_alive,
        .rd_addr, .wr_en, .wr_addr, .wr_alive, .gen_done, .sx, .sy,
        .hsync_in(timing_hsync), .vsync_in(timing_vsync), .de_in(timing_de),
        .frame_start, .rd_alive, .red, .green, .blue,
        .hsync, .vsync, .de, .generation_pulse
    );

endmodule

/* world_store.sv */
// world store and pixel stage
// double-buffered cell world with seed port, swap on frame start and colour out
`timescale 1ns/1ps
`include "life_params.svh"

module world_store (
    input  logic                 clk_pix,
    input  logic                 rst_n,
    input  logic                 run,
    input  logic                 seed_we,
    input  life_pkg::cell_x_t    seed_x,
    input  life_pkg::cell_y_t    seed_y,
    input  logic                 seed_alive,
    input  life_pkg::cell_addr_t rd_addr,      // engine read of the front world
    input  logic                 wr_en,        // engine write of the back world
    input  life_pkg::cell_addr_t wr_addr,
    input  logic                 wr_alive,
    input  logic                 gen_done,
    input  video_pkg::coord_t    sx,
    input  video_pkg::coord_t    sy,
    input  logic                 hsync_in,
    input  logic                 vsync_in,
    input  logic                 de_in,
    input  logic                 frame_start,
    output logic                 rd_alive,
    output video_pkg::chan_t     red,
    output video_pkg::chan_t     green,
    output video_pkg::chan_t     blue,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 de,
    output logic                 generation_pulse  // one cycle per swap
);
    import video_pkg::*;
    import life_pkg::*;

    localparam int          CELLS = `LIFE_WORLD_W * `LIFE_WORLD_H;
    localparam logic [11:0] ALIVE = `LIFE_ALIVE_COLOR;
    localparam logic [11:0] DEAD  = `LIFE_DEAD_COLOR;

    logic       cells_a [CELLS];
    logic       cells_b [CELLS];
    logic       front_sel;       // 0 shows cells_a
    logic       swap_pend;       // back world complete
    logic       take_swap;
    logic       disp_sel;        // front for the pixel read this cycle
    logic       seed_wr;
    cell_addr_t seed_addr;
    cell_addr_t pix_addr;
    logic       pix_alive;

    assign take_swap = frame_start && swap_pend && run;
    assign disp_sel  = front_sel ^ take_swap;  // new world from the first pixel on
    assign seed_wr   = seed_we && !run && (seed_y < cell_y_t'(`LIFE_WORLD_H));
    assign seed_addr = cell_addr_t'(seed_y * `LIFE_WORLD_W + seed_x);
    assign pix_addr  = cell_addr_t'((sy >> `LIFE_SCALE_SHIFT) * `LIFE_WORLD_W
                                    + (sx >> `LIFE_SCALE_SHIFT));
    assign pix_alive = disp_sel ? cells_b[pix_addr] : cells_a[pix_addr];

    // engine writes the back world, seeding writes the front world
    always_ff @(posedge clk_pix) begin
        if (wr_en) begin
            if (front_sel)
                cells_a[wr_addr] <= wr_alive;
            else
                cells_b[wr_addr] <= wr_alive;
        end
        if (seed_wr) begin
            if (front_sel)
                cells_b[seed_addr] <= seed_alive;
            else
                cells_a[seed_addr] <= seed_alive;
        end
        rd_alive <= front_sel ? cells_b[rd_addr] : cells_a[rd_addr];
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            front_sel        <= 1'b0;
            swap_pend        <= 1'b0;
            generation_pulse <= 1'b0;
        end else begin
            generation_pulse <= take_swap;
            if (take_swap) begin
                front_sel <= ~front_sel;
                swap_pend <= 1'b0;
            end else if (gen_done) begin
                swap_pend <= 1'b1;                   // wait for the next frame
            end
        end
    end

    // pixel stage, one cycle behind the counters
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
            hsync <= 1'b0;
            vsync <= 1'b0;
            de    <= 1'b0;
        end else begin
            red   <= !de_in ? chan_t'(0) : (pix_alive ? ALIVE[11:8] : DEAD[11:8]);
            green <= !de_in ? chan_t'(0) : (pix_alive ? ALIVE[7:4] : DEAD[7:4]);
            blue  <= !de_in ? chan_t'(0) : (pix_alive ? ALIVE[3:0] : DEAD[3:0]);
            hsync <= hsync_in;
            vsync <= vsync_in;
            de    <= de_in;
        end
    end

endmodule

/* display_timing.sv */
// display timing
// raster counters with sync, data enable and frame start from the params header
`timescale 1ns/1ps
`include "life_params.svh"

module display_timing (
    input  logic              clk_pix,
    input  logic              rst_n,
    output video_pkg::coord_t sx,          // horizontal position
    output video_pkg::coord_t sy,          // vertical position
    output logic              hsync,
    output logic              vsync,
    output logic              de,          // active area
    output logic              frame_start  // first cycle of a frame
);
    import video_pkg::*;

    localparam coord_t H_LAST = coord_t'(`LIFE_H_TOTAL - 1);
    localparam coord_t V_LAST = coord_t'(`LIFE_V_TOTAL - 1);

    localparam coord_t H_ACT = coord_t'(`LIFE_H_ACTIVE);
    localparam coord_t V_ACT = coord_t'(`LIFE_V_ACTIVE);

    localparam coord_t HS_START = coord_t'(`LIFE_H_SYNC_START);
    localparam coord_t HS_END   = coord_t'(`LIFE_H_SYNC_END);
    localparam coord_t VS_START = coord_t'(`LIFE_V_SYNC_START);
    localparam coord_t VS_END   = coord_t'(`LIFE_V_SYNC_END);

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == H_LAST) begin
            sx <= '0;                                    // end of line
            sy <= (sy == V_LAST) ? '0 : sy + coord_t'(1);
        end else begin
            sx <= sx + coord_t'(1);
        end
    end

    // decoded straight from the counters
    assign hsync       = (sx >= HS_START) && (sx < HS_END);
    assign vsync       = (sy >= VS_START) && (sy < VS_END);
    assign de          = (sx < H_ACT) && (sy < V_ACT);
    assign frame_start = (sx == '0) && (sy == '0);

endmodule

/* life_engine.sv */
// life engine
// computes the next generation cell by cell from the front world into the back world
// a 3x3 window is read one cell per cycle, edges of the world count as dead
`timescale 1ns/1ps
`include "life_params.svh"

module life_engine (
    input  logic                 clk_pix,
    input  logic                 rst_n,
    input  logic                 gen_req,   // from frame pacer
    input  logic                 rd_alive,  // front cell, one cycle after rd_addr
    output logic                 gen_ack,   // generation complete
    output logic                 gen_done,  // one cycle, with the ack rise
    output life_pkg::cell_addr_t rd_addr,
    output logic                 wr_en,
    output life_pkg::cell_addr_t wr_addr,
    output logic                 wr_alive
);
    import life_pkg::*;

    localparam cell_x_t LAST_X = cell_x_t'(`LIFE_WORLD_W - 1);
    localparam cell_y_t LAST_Y = cell_y_t'(`LIFE_WORLD_H - 1);

    engine_state_t state;
    cell_x_t       cx;            // cell being computed
    cell_y_t       cy;
    logic [1:0]    wx;            // window column 0..2
    logic [1:0]    wy;            // window row, 3 once all nine are issued
    logic [4:0]    nx;            // neighbour column, -1 wraps high
    logic [4:0]    ny;
    logic          in_world;
    logic          issue;         // window read goes out this cycle
    logic          a_valid;       // stage a matches rd_addr
    logic          a_centre;
    logic          a_last;
    logic          b_valid;       // stage b matches rd_alive
    logic          b_centre;
    logic          b_last;
    logic [3:0]    n_cnt;         // live neighbours so far
    logic [3:0]    n_final;       // sum including the last window read
    logic          centre_alive;

    assign nx       = {1'b0, cx} + {3'b000, wx} - 5'd1;
    assign ny       = {1'b0, cy} + {3'b000, wy} - 5'd1;
    assign in_world = (nx < 5'(`LIFE_WORLD_W)) && (ny < 5'(`LIFE_WORLD_H));
    assign issue    = ((state == LOAD) || (state == COUNT)) && (wy != 2'd3);
    assign n_final  = n_cnt + {3'b000, b_valid && rd_alive};  // last read is never the centre

    // state, handshake and read pipeline control
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            state    <= IDLE;
            gen_ack  <= 1'b0;
            gen_done <= 1'b0;
            wr_en    <= 1'b0;
            cx       <= '0;
            cy       <= '0;
            wx       <= '0;
            wy       <= '0;
            a_valid  <= 1'b0;
            a_last   <= 1'b0;
            b_valid  <= 1'b0;
            b_last   <= 1'b0;
        end else begin
            gen_done <= 1'b0;
            wr_en    <= 1'b0;
            a_valid  <= issue && in_world;             // outside cells are not read
            a_last   <= issue && (wx == 2'd2) && (wy == 2'd2);
            b_valid  <= a_valid;
            b_last   <= a_last;
            if (issue) begin
                if (wx == 2'd2) begin
                    wx <= '0;
                    wy <= wy + 2'd1;
                end else begin
                    wx <= wx + 2'd1;
                end
            end
            case (state)
                IDLE: begin
                    if (gen_req) begin
                        cx    <= '0;
                        cy    <= '0;
                        state <= LOAD;
                    end
                end
                LOAD: state <= COUNT;
                COUNT: begin
                    if (b_last) begin                  // whole window summed
                        wr_en <= 1'b1;
                        state <= WRITE;
                    end
                end
                WRITE: begin
                    wx <= '0;
                    wy <= '0;
                    if (cx == LAST_X) begin
                        cx <= '0;
                        if (cy == LAST_Y) begin
                            gen_ack  <= 1'b1;          // phase 2
                            gen_done <= 1'b1;
                            state    <= FINISH;
                        end else begin
                            cy    <= cy + 1'b1;
                            state <= LOAD;
                        end
                    end else begin
                        cx    <= cx + 1'b1;
                        state <= LOAD;
                    end
                end
                FINISH: begin
                    if (!gen_req) begin
                        gen_ack <= 1'b0;               // phase 4
                        state   <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // read address, neighbour sum and rule
    always_ff @(posedge clk_pix) begin
        if (issue)
            rd_addr <= cell_addr_t'(ny * `LIFE_WORLD_W + nx);
        a_centre <= (wx == 2'd1) && (wy == 2'd1);
        b_centre <= a_centre;
        if (state == LOAD) begin
            n_cnt <= '0;
        end else if (b_valid) begin
            if (b_centre)
                centre_alive <= rd_alive;
            else
                n_cnt <= n_cnt + {3'b000, rd_alive};
        end
        if ((state == COUNT) && b_last) begin
            wr_addr  <= cell_addr_t'(cy * `LIFE_WORLD_W + cx);
            wr_alive <= (n_final == 4'd3) || (centre_alive && (n_final == 4'd2));
        end
    end

endmodule

/* frame_pacer.sv */
// frame pacer
// counts frames while run is high and requests a generation every few frames
`timescale 1ns/1ps
`include "life_params.svh"

module frame_pacer (
    input  logic clk_pix,
    input  logic rst_n,
    input  logic run,          // world evolves while high
    input  logic frame_start,  // one cycle at the start of each frame
    input  logic gen_ack,      // engine finished the generation
    output logic gen_req       // four-phase request to the engine
);
    localparam int CNT_W = $clog2(`LIFE_GEN_FRAMES + 1);

    logic [CNT_W-1:0] frame_cnt;
    logic             last_frame;  // this frame completes the count
    logic             hs_open;     // request or ack still high
    logic             req_wait;    // count reached while handshake open

    assign last_frame = run && frame_start && (frame_cnt == CNT_W'(`LIFE_GEN_FRAMES - 1));
    assign hs_open    = gen_req || gen_ack;

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            frame_cnt <= '0;
            gen_req   <= 1'b0;
            req_wait  <= 1'b0;
        end else begin
            if (!run)
                frame_cnt <= '0;                        // pacing restarts on next run
            else if (frame_start)
                frame_cnt <= last_frame ? '0 : frame_cnt + 1'b1;

            if (gen_req && gen_ack)
                gen_req <= 1'b0;                        // phase 3, drop after ack
            else if (run && (last_frame || req_wait) && !hs_open)
                gen_req <= 1'b1;                        // phase 1

            if (!run)
                req_wait <= 1'b0;
            else if (last_frame && hs_open)
                req_wait <= 1'b1;                       // frame counted, request held
            else if (!hs_open)
                req_wait <= 1'b0;
        end
    end

endmodule

/* life_pkg.sv */
// world types
// cell positions, linear cell index and the engine state machine
package life_pkg;

    typedef logic [3:0] cell_x_t;     // cell column
    typedef logic [3:0] cell_y_t;     // cell row
    typedef logic [7:0] cell_addr_t;  // row * width + column

    // life engine states
    typedef enum logic [2:0] {
        IDLE,    // waiting for a generation request
        LOAD,    // new cell, first window read
        COUNT,   // window reads and neighbour sum
        WRITE,   // next state into the back world
        FINISH   // ack high until the request drops
    } engine_state_t;

endpackage

/* video_pkg.sv */
// video types
// screen coordinates and colour channels of the pixel path
package video_pkg;

    // one screen coordinate, covers the full 80 x 56 raster
    typedef logic [7:0] coord_t;

    // one colour channel of a 12-bit RGB pixel
    typedef logic [3:0] chan_t;

endpackage

/* life_params.svh */
// Game of Life display parameters
// raster timing with reduced blanking, world geometry, pacing and colours
`ifndef LIFE_PARAMS_SVH
`define LIFE_PARAMS_SVH

// horizontal timing in pixels, syncs active high
`define LIFE_H_ACTIVE     64
`define LIFE_H_TOTAL      80
`define LIFE_H_SYNC_START 68
`define LIFE_H_SYNC_END   74

// vertical timing in lines
`define LIFE_V_ACTIVE     48
`define LIFE_V_TOTAL      56
`define LIFE_V_SYNC_START 50
`define LIFE_V_SYNC_END   52

// world of 16 x 12 cells, each 4 x 4 pixels
`define LIFE_WORLD_W      16
`define LIFE_WORLD_H      12
`define LIFE_SCALE_SHIFT  2

`define LIFE_GEN_FRAMES   2        // frames per generation

`define LIFE_ALIVE_COLOR  12'hEE4  // 4 bits each of red, green, blue
`define LIFE_DEAD_COLOR   12'h125

`endif
